// ==== src/pe_mac_pkg.sv ====
package pe_mac_pkg;

    //////////////////////////////////////////////////
    // array geometry
    //////////////////////////////////////////////////

    // parallel multiply lanes per element
    localparam int LANES = 8;

    // weight and activation width
    localparam int DATA_W = 8;

    // sparse index width, enough to address every lane
    localparam int IDX_W = 3;

    // full product of two operands
    localparam int PROD_W = 2 * DATA_W;

    // accumulator width
    localparam int ACC_W = 16;

    //////////////////////////////////////////////////
    // saturation limits
    //////////////////////////////////////////////////

    // largest positive accumulator value
    localparam logic signed [ACC_W-1:0] ACC_MAX = {1'b0, {(ACC_W - 1){1'b1}}};

    // most negative accumulator value
    localparam logic signed [ACC_W-1:0] ACC_MIN = {1'b1, {(ACC_W - 1){1'b0}}};

    //////////////////////////////////////////////////
    // payload types
    //////////////////////////////////////////////////

    // single signed activation
    typedef logic signed [DATA_W-1:0] act_t;

    // single signed accumulator value
    typedef logic signed [ACC_W-1:0] acc_t;

    // one lane of a compressed weight vector
    // weight sits above its index, as on the wire
    typedef struct packed {
        act_t             weight;
        logic [IDX_W-1:0] idx;
    } weight_entry_t;

    // entry 0 in the low bits
    typedef weight_entry_t [LANES-1:0] weight_vec_t;

    // activation 0 in the low bits
    typedef act_t [LANES-1:0] act_vec_t;

    // one accumulator per lane
    typedef acc_t [LANES-1:0] acc_vec_t;

    //////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////

    // level inputs, sampled every cycle
    // low enable behaves like a held clear
    typedef struct packed {
        logic en;
        logic clear;
    } mac_ctrl_t;

endpackage

// ==== src/stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg
    import pe_mac_pkg::*;
#(
    // payload carried by this stage
    parameter type T = act_vec_t
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  T     i_data,
    input  logic i_vld,
    output T     o_data,
    output logic o_vld
);

    //////////////////////////////////////////////////
    // held payload
    //////////////////////////////////////////////////

    T     data_q;
    logic vld_q;

    // load only on the strobe
    // payload stays put until the next one
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_q <= '0;
        end else if (i_vld) begin
            data_q <= i_data;
        end
    end

    //////////////////////////////////////////////////
    // delayed strobe
    //////////////////////////////////////////////////

    // one cycle behind the input strobe
    // lines up with the payload it announces
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= i_vld;
        end
    end

    // to the neighbor and to the local datapath
    assign o_data = data_q;
    assign o_vld  = vld_q;

endmodule

// ==== src/sparse_gather.sv ====
`timescale 1ns/1ns

module sparse_gather
    import pe_mac_pkg::*;
(
    input  act_vec_t    i_act,
    input  weight_vec_t i_weights,
    output act_vec_t    o_operand
);

    //////////////////////////////////////////////////
    // per-lane index mux
    //////////////////////////////////////////////////

    // index 0 picks the top activation
    // index LANES-1 picks activation 0
    for (genvar g = 0; g < LANES; g++) begin : g_lane

        weight_entry_t    entry;
        logic [LANES-1:0] hit;
        act_t             sel;

        assign entry = i_weights[g];

        // one-hot decode of the stored index
        // bit j set when this lane wants activation j
        always_comb begin
            for (int j = 0; j < LANES; j++) begin
                hit[j] = (entry.idx == IDX_W'(LANES - 1 - j));
            end
        end

        // and-or select over the held vector
        // exactly one hit since the index covers all lanes
        always_comb begin
            sel = '0;
            for (int j = 0; j < LANES; j++) begin
                sel = sel | (i_act[j] & {DATA_W{hit[j]}});
            end
        end

        // operand for lane g
        assign o_operand[g] = sel;

    end

endmodule

// ==== src/mac_lane.sv ====
`timescale 1ns/1ns

module mac_lane
    import pe_mac_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  act_t i_weight,
    input  act_t i_operand,
    input  logic i_acc_vld,
    input  logic i_clear,
    output acc_t o_acc
);

    //////////////////////////////////////////////////
    // multiply
    //////////////////////////////////////////////////

    logic signed [PROD_W-1:0] prod;
    acc_t                     prod_ext;
    acc_t                     sum;
    acc_t                     sat_sum;
    acc_t                     acc_q;
    logic                     acc_sign;
    logic                     prod_sign;
    logic                     sum_sign;
    logic                     ovf;

    // both operands signed, full width product
    assign prod = i_weight * i_operand;

    // fit the product to the accumulator, sign kept
    assign prod_ext = ACC_W'(prod);

    //////////////////////////////////////////////////
    // saturating add
    //////////////////////////////////////////////////

    // wrapping sum, fixed up below
    assign sum = acc_q + prod_ext;

    assign acc_sign  = acc_q[ACC_W-1];
    assign prod_sign = prod_ext[ACC_W-1];
    assign sum_sign  = sum[ACC_W-1];

    // overflow only when both addends share a sign
    // and the sum comes out with the other one
    assign ovf = (acc_sign == prod_sign) && (sum_sign != acc_sign);

    // clamp toward the side the addends were on
    always_comb begin
        if (!ovf) begin
            sat_sum = sum;
        end else if (acc_sign) begin
            sat_sum = ACC_MIN;
        end else begin
            sat_sum = ACC_MAX;
        end
    end

    //////////////////////////////////////////////////
    // accumulator
    //////////////////////////////////////////////////

    // clear wins over an accumulate in the same cycle
    // otherwise load on the registered weight strobe, else hold
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            acc_q <= '0;
        end else if (i_clear) begin
            acc_q <= '0;
        end else if (i_acc_vld) begin
            acc_q <= sat_sum;
        end
    end

    // running total
    assign o_acc = acc_q;

endmodule

// ==== src/pe_mac_top.sv ====
`timescale 1ns/1ns

module pe_mac_top
    import pe_mac_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    // weight strobe side
    input  weight_vec_t i_wdata,
    input  logic        i_wdata_vld,
    // activation strobe side
    input  act_vec_t    i_mdata,
    input  logic        i_mdata_vld,
    // level control
    input  mac_ctrl_t   i_ctrl,
    // forwarded to the next element
    output weight_vec_t o_wdata,
    output logic        o_wdata_vld,
    output act_vec_t    o_mdata,
    output logic        o_mdata_vld,
    // per-lane accumulators
    output acc_vec_t    o_acc
);

    //////////////////////////////////////////////////
    // operand stages
    //////////////////////////////////////////////////

    weight_vec_t held_w;
    act_vec_t    held_act;
    act_vec_t    operand;
    logic        w_vld_q;
    logic        mac_clear;

    // weights, the registered strobe also drives accumulation
    stage_reg #(
        .T(weight_vec_t)
    ) u_wstage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_wdata),
        .i_vld   (i_wdata_vld),
        .o_data  (held_w),
        .o_vld   (w_vld_q)
    );

    // activations
    stage_reg #(
        .T(act_vec_t)
    ) u_mstage (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_mdata),
        .i_vld   (i_mdata_vld),
        .o_data  (held_act),
        .o_vld   (o_mdata_vld)
    );

    // forward held payloads unchanged
    assign o_wdata     = held_w;
    assign o_wdata_vld = w_vld_q;
    assign o_mdata     = held_act;

    //////////////////////////////////////////////////
    // sparse operand select
    //////////////////////////////////////////////////

    // each lane's index picks from the held activations
    sparse_gather u_gather (
        .i_act     (held_act),
        .i_weights (held_w),
        .o_operand (operand)
    );

    //////////////////////////////////////////////////
    // lanes
    //////////////////////////////////////////////////

    // explicit clear or a dropped enable
    assign mac_clear = i_ctrl.clear | ~i_ctrl.en;

    for (genvar g = 0; g < LANES; g++) begin : g_mac

        // weight g against its gathered activation
        mac_lane u_lane (
            .i_clk     (i_clk),
            .i_rst_n   (i_rst_n),
            .i_weight  (held_w[g].weight),
            .i_operand (operand[g]),
            .i_acc_vld (w_vld_q),
            .i_clear   (mac_clear),
            .o_acc     (o_acc[g])
        );

    end

endmodule

// ==== test/pe_mac_properties.sv ====
`timescale 1ns/1ns

module pe_mac_properties
    import pe_mac_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_wdata_vld,
    input logic      i_mdata_vld,
    input mac_ctrl_t i_ctrl,
    input logic      i_fwd_wvld,
    input logic      i_fwd_mvld,
    input acc_vec_t  i_acc
);

    //////////////////////////////////////////////////
    // forwarding
    //////////////////////////////////////////////////

    int unsigned fail_count = 0;
    logic        clear_req;

    // same condition the lanes use
    assign clear_req = i_ctrl.clear | ~i_ctrl.en;

    a_wvld_fwd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fwd_wvld == $past(i_wdata_vld))
    else begin
        $error("forwarded weight valid does not follow the input strobe");
        fail_count++;
    end

    a_mvld_fwd: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_fwd_mvld == $past(i_mdata_vld))
    else begin
        $error("forwarded activation valid does not follow the input strobe");
        fail_count++;
    end

    //////////////////////////////////////////////////
    // accumulators
    //////////////////////////////////////////////////

    // zero one cycle after a clear
    a_clear_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        clear_req |=> (i_acc == '0))
    else begin
        $error("accumulators not zero after a clear");
        fail_count++;
    end

    // no registered weight strobe, no change
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_fwd_wvld && !clear_req) |=> $stable(i_acc))
    else begin
        $error("accumulator changed without a weight strobe");
        fail_count++;
    end

endmodule

bind pe_mac_top pe_mac_properties u_props (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_wdata_vld (i_wdata_vld),
    .i_mdata_vld (i_mdata_vld),
    .i_ctrl      (i_ctrl),
    .i_fwd_wvld  (o_wdata_vld),
    .i_fwd_mvld  (o_mdata_vld),
    .i_acc       (o_acc)
);

// ==== test/tb_pe_mac.sv ====
`timescale 1ns/1ns

module tb_pe_mac
    import pe_mac_pkg::*;
();

    //////////////////////////////////////////////////
    // run limits
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    // upper bound on strobes over all tests, each strobe under 4 cycles
    localparam int NUM_STROBES   = 40;
    localparam int STROBE_CYCLES = 4;
    localparam int MARGIN_CYCLES = 64;
    localparam int WATCHDOG_CYCLES =
        NUM_STROBES * STROBE_CYCLES + RESET_CYCLES + MARGIN_CYCLES;

    logic        clk;
    logic        rst_n;
    weight_vec_t wdata;
    logic        wdata_vld;
    act_vec_t    mdata;
    logic        mdata_vld;
    mac_ctrl_t   ctrl;
    weight_vec_t o_wdata;
    logic        o_wdata_vld;
    act_vec_t    o_mdata;
    logic        o_mdata_vld;
    acc_vec_t    o_acc;

    // reference model state
    int          model_acc [LANES];
    act_vec_t    model_act;

    pe_mac_top u_dut (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wdata     (wdata),
        .i_wdata_vld (wdata_vld),
        .i_mdata     (mdata),
        .i_mdata_vld (mdata_vld),
        .i_ctrl      (ctrl),
        .o_wdata     (o_wdata),
        .o_wdata_vld (o_wdata_vld),
        .o_mdata     (o_mdata),
        .o_mdata_vld (o_mdata_vld),
        .o_acc       (o_acc)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////
    // failure and compare tasks
    //////////////////////////////////////////////////

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_weights(input string name, input weight_vec_t got,
                                 input weight_vec_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_acts(input string name, input act_vec_t got, input act_vec_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_acc(input string name, input acc_vec_t got, input acc_vec_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                                        $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Mismatch at %0t ns: %s got %b expected %b",
                                        $time, name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // index 0 reads the top activation, then saturate to 16 bits
    task automatic model_step(input weight_vec_t w);
        act_t sel;
        int   sum;
        for (int i = 0; i < LANES; i++) begin
            if (ctrl.clear || !ctrl.en) begin
                model_acc[i] = 0;
            end else begin
                sel = model_act[LANES - 1 - w[i].idx];
                sum = model_acc[i] + int'(w[i].weight) * int'(sel);
                if (sum > 32767) begin
                    sum = 32767;
                end else if (sum < -32768) begin
                    sum = -32768;
                end
                model_acc[i] = sum;
            end
        end
    endtask

    function automatic acc_vec_t expected_acc();
        acc_vec_t v;
        for (int i = 0; i < LANES; i++) begin
            v[i] = acc_t'(model_acc[i]);
        end
        return v;
    endfunction

    function automatic weight_vec_t rand_weights();
        weight_vec_t w;
        for (int i = 0; i < LANES; i++) begin
            w[i].weight = act_t'($urandom);
            w[i].idx    = IDX_W'($urandom);
        end
        return w;
    endfunction

    function automatic act_vec_t rand_acts();
        act_vec_t a;
        for (int i = 0; i < LANES; i++) begin
            a[i] = act_t'($urandom);
        end
        return a;
    endfunction

    //////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////

    // strobe for one cycle, forwarded a cycle later, summed the cycle after
    task automatic send_weights(input weight_vec_t w);
        @(negedge clk);
        wdata     = w;
        wdata_vld = 1'b1;
        @(negedge clk);
        wdata     = '0;
        wdata_vld = 1'b0;
        check_bit("o_wdata_vld", o_wdata_vld, 1'b1);
        check_weights("o_wdata", o_wdata, w);
        check_acc("o_acc", o_acc, expected_acc());
        model_step(w);
        @(negedge clk);
        check_bit("o_wdata_vld", o_wdata_vld, 1'b0);
        check_weights("o_wdata", o_wdata, w);
        check_acc("o_acc", o_acc, expected_acc());
    endtask

    // activations alone never touch the accumulators
    task automatic send_acts(input act_vec_t a);
        @(negedge clk);
        mdata     = a;
        mdata_vld = 1'b1;
        @(negedge clk);
        mdata     = '0;
        mdata_vld = 1'b0;
        check_bit("o_mdata_vld", o_mdata_vld, 1'b1);
        check_acts("o_mdata", o_mdata, a);
        check_acc("o_acc", o_acc, expected_acc());
        @(negedge clk);
        check_bit("o_mdata_vld", o_mdata_vld, 1'b0);
        check_acts("o_mdata", o_mdata, a);
        check_acc("o_acc", o_acc, expected_acc());
        model_act = a;
    endtask

    task automatic pulse_clear();
        @(negedge clk);
        ctrl.clear = 1'b1;
        @(negedge clk);
        ctrl.clear = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            model_acc[i] = 0;
        end
        check_acc("o_acc", o_acc, '0);
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////

    task automatic test_forwarding();
        // reset state first
        check_bit("o_wdata_vld", o_wdata_vld, 1'b0);
        check_bit("o_mdata_vld", o_mdata_vld, 1'b0);
        check_weights("o_wdata", o_wdata, '0);
        check_acts("o_mdata", o_mdata, '0);
        check_acc("o_acc", o_acc, '0);
        send_acts(rand_acts());
        send_weights(rand_weights());
    endtask

    task automatic test_gather_accumulate();
        pulse_clear();
        send_acts(rand_acts());
        repeat (10) send_weights(rand_weights());
    endtask

    task automatic test_saturation();
        weight_vec_t w;
        act_vec_t    a;
        acc_vec_t    lim;
        pulse_clear();
        for (int i = 0; i < LANES; i++) begin
            a[i]        = 8'sd127;
            w[i].weight = 8'sd127;
            w[i].idx    = IDX_W'(i);
        end
        send_acts(a);
        // 127*127 three times already passes 32767
        repeat (4) send_weights(w);
        for (int i = 0; i < LANES; i++) begin
            lim[i] = 16'sh7fff;
        end
        check_acc("o_acc", o_acc, lim);
        for (int i = 0; i < LANES; i++) begin
            w[i].weight = 8'sh80;
        end
        repeat (6) send_weights(w);
        for (int i = 0; i < LANES; i++) begin
            lim[i] = 16'sh8000;
        end
        check_acc("o_acc", o_acc, lim);
    endtask

    task automatic test_clear_enable();
        send_acts(rand_acts());
        send_weights(rand_weights());
        pulse_clear();
        send_weights(rand_weights());
        // dropped enable acts as a held clear
        @(negedge clk);
        ctrl.en = 1'b0;
        @(negedge clk);
        for (int i = 0; i < LANES; i++) begin
            model_acc[i] = 0;
        end
        check_acc("o_acc", o_acc, '0);
        send_weights(rand_weights());
        check_acc("o_acc", o_acc, '0);
        @(negedge clk);
        ctrl.en = 1'b1;
    endtask

    task automatic test_act_reload();
        send_acts(rand_acts());
        send_weights(rand_weights());
        // new vector, accumulators must hold
        send_acts(rand_acts());
        send_weights(rand_weights());
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int unsigned seed_val;
        seed_val   = 74;
        void'($urandom(seed_val));
        rst_n      = 1'b0;
        wdata      = '0;
        wdata_vld  = 1'b0;
        mdata      = '0;
        mdata_vld  = 1'b0;
        ctrl.en    = 1'b1;
        ctrl.clear = 1'b0;
        model_act  = '0;
        for (int i = 0; i < LANES; i++) begin
            model_acc[i] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_forwarding();
        test_gather_accumulate();
        test_saturation();
        test_clear_enable();
        test_act_reload();
        @(negedge clk);
        // bound assertion block keeps its own failure count
        if (u_dut.u_props.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "concurrent assertions failed during the run");
        end
    end

endmodule

// ==== vlog.f ====
src/pe_mac_pkg.sv
src/stage_reg.sv
src/sparse_gather.sv
src/mac_lane.sv
src/pe_mac_top.sv
test/pe_mac_properties.sv
test/tb_pe_mac.sv
